/* Makefile */
TOP = vecMulTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vecMulTop.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* hw/elemCounter.sv */
`timescale 1ns/1ps

module elemCounter import vecMulPkg::*; #(
	parameter int DEPTH = 64
) (
	input  logic                     aclk,
	input  logic                     rst,
	input  logic                     aclken,
	input  logic                     clear,
	input  logic                     count,
	input  vecCmd_s                  limit,
	output logic [$clog2(DEPTH)-1:0] idx,
	output logic                     last
);

	localparam int AW = $clog2(DEPTH);

	always_ff @(posedge aclk) begin
		if (rst) begin
			idx <= '0;
		end else if (aclken) begin
			if (clear)
				idx <= '0; // New run
			else if (count)
				idx <= idx + 1'b1;
		end
	end

	// Final element of the run
	assign last = (idx == AW'(limit.len - 8'd1));

	// Matters for DEPTH that is not a power of two
	idxInRange: assert property (@(posedge aclk) disable iff (rst)
		int'(idx) < DEPTH)
		else $error("elemCounter index %0d beyond DEPTH", idx);

endmodule

/* hw/fp16Mul.sv */
`timescale 1ns/1ps

module fp16Mul import fpFormatPkg::*, vecMulPkg::*; (
	input  logic       aclk,
	input  logic       rst,
	input  logic       aclken,
	input  logic       inVld,
	input  opPair_s    inPair,
	output logic       outVld,
	output mulResult_s outRes
);

	opPair_s    inReg; // Stage 1
	logic       inVldR;
	prepStage_s prepC;
	prepStage_s prepReg; // Stage 2
	logic       prepVld;
	normStage_s normC;
	normStage_s normReg; // Stage 3
	logic       normVld;

	// Unpack and mantissa multiply
	fp16MulPrep uPrep (
		.opA  (inReg.a),
		.opB  (inReg.b),
		.prep (prepC)
	);

	// Normalize and round
	fp16MulNormRound uNormRound (
		.prep (prepReg),
		.norm (normC)
	);

	// One valid bit per stage
	always_ff @(posedge aclk) begin
		if (rst) begin
			inVldR  <= 1'b0;
			prepVld <= 1'b0;
			normVld <= 1'b0;
			outVld  <= 1'b0;
		end else if (aclken) begin
			inVldR  <= inVld;
			prepVld <= inVldR;
			normVld <= prepVld;
			outVld  <= normVld; // Four enabled cycles after inVld
		end
	end

	// Whole data path freezes together
	always_ff @(posedge aclk) begin
		if (aclken) begin
			inReg       <= inPair;
			prepReg     <= prepC;
			normReg     <= normC;
			outRes.prod <= normReg.res;
			outRes.exc  <= normReg.exc;
		end
	end

	// Result buffer write enable must be clean once out of reset
	outVldKnown: assert property (@(posedge aclk) disable iff (rst)
		!$isunknown(outVld))
		else $error("fp16Mul outVld unknown");

endmodule

/* hw/fp16MulNormRound.sv */
`timescale 1ns/1ps

module fp16MulNormRound import fpFormatPkg::*; (
	input  prepStage_s prep,
	output normStage_s norm
);

	logic        hi; // Product at or above 2.0
	logic [9:0]  kept;
	logic        guard;
	logic        sticky;
	logic        roundUp;
	logic [5:0]  expNorm;
	logic [10:0] mantRnd; // Carry in bit 10
	logic        carry;
	logic [9:0]  mantFin;
	logic [5:0]  expFin;

	assign hi = prep.mantProd[21];

	// Drop the leading one, keep ten fraction bits
	assign kept = hi ? prep.mantProd[20:11] : prep.mantProd[19:10];

	// First bit below the kept field
	assign guard = hi ? prep.mantProd[10] : prep.mantProd[9];

	// Everything under the guard
	assign sticky = hi ? (|prep.mantProd[9:0]) : (|prep.mantProd[8:0]);

	// Shift right by one bumps the exponent, then take one bias off
	assign expNorm = prep.expSum + {5'd0, hi} - FP_BIAS; // Over and underflow not handled

	// Nearest even
	// on a tie only an odd kept bit rounds up
	assign roundUp = guard & (sticky | kept[0]);

	assign mantRnd = {1'b0, kept} + {10'd0, roundUp};
	assign carry   = mantRnd[10]; // Fraction was all ones

	// Carry out means 10.0, so renormalize to 1.0 with the next exponent
	assign mantFin = carry ? 10'd0 : mantRnd[9:0];
	assign expFin  = expNorm + {5'd0, carry};

	assign norm.res.f.sign = prep.sign;
	assign norm.res.f.exp  = expFin[4:0]; // Sixth bit would only show overflow
	assign norm.res.f.mant = mantFin;
	assign norm.exc        = prep.exc; // Flags ride along unchanged

endmodule

/* hw/fp16MulPrep.sv */
`timescale 1ns/1ps

module fp16MulPrep import fpFormatPkg::*; (
	input  fp16Word_u  opA,
	input  fp16Word_u  opB,
	output prepStage_s prep
);

	fp16Fields_s fa;
	fp16Fields_s fb;
	logic [10:0] manA; // With hidden one
	logic [10:0] manB;
	logic        expOnesA;
	logic        expOnesB;
	excFlags_s   exc;

	// Field view of both operands
	assign fa = opA.f;
	assign fb = opB.f;

	// Zero and subnormal inputs still get the hidden one
	assign manA = {1'b1, fa.mant};
	assign manB = {1'b1, fb.mant};

	assign expOnesA = &fa.exp;
	assign expOnesB = &fb.exp;

	// All ones exponent, nonzero fraction
	assign exc.aNaN = expOnesA & (|fa.mant);
	assign exc.bNaN = expOnesB & (|fb.mant);
	// All ones exponent, zero fraction
	assign exc.aInf = expOnesA & ~(|fa.mant);
	assign exc.bInf = expOnesB & ~(|fb.mant);
	assign exc.anyExc = exc.aNaN | exc.bNaN | exc.aInf | exc.bInf;

	// Word is still built arithmetically for exception inputs
	assign prep.sign     = fa.sign ^ fb.sign; // Equal signs give positive
	assign prep.expSum   = {1'b0, fa.exp} + {1'b0, fb.exp}; // Bias removed later
	assign prep.mantProd = manA * manB; // Top bit set means product in [2,4)
	assign prep.exc      = exc;

endmodule

/* hw/fpFormatPkg.sv */
package fpFormatPkg;

	// IEEE half precision fields with the sign as MSB
	typedef struct packed {
		logic       sign;
		logic [4:0] exp; // Biased exponent
		logic [9:0] mant; // Fraction without the hidden one
	} fp16Fields_s;

	// Buffers move the raw word, the multiplier decodes the fields
	typedef union packed {
		logic [15:0] raw;
		fp16Fields_s f;
	} fp16Word_u;

	// Input exception summary with anyExc on top
	typedef struct packed {
		logic anyExc;
		logic aNaN;
		logic bNaN;
		logic aInf;
		logic bInf;
	} excFlags_s;

	// Prep to normalize
	typedef struct packed {
		logic        sign;
		logic [5:0]  expSum; // Ea + Eb with the bias counted twice
		logic [21:0] mantProd; // 11 x 11 bit product
		excFlags_s   exc;
	} prepStage_s;

	// Normalize to output register
	typedef struct packed {
		fp16Word_u res;
		excFlags_s exc;
	} normStage_s;

	// One result buffer entry of 21 bits
	typedef struct packed {
		fp16Word_u prod;
		excFlags_s exc;
	} mulResult_s;

	localparam logic [5:0] FP_BIAS = 6'd15;

endpackage

/* hw/vecMulCtrl.sv */
`timescale 1ns/1ps

module vecMulCtrl import vecMulPkg::*; (
	input  logic    aclk,
	input  logic    rst,
	input  logic    aclken,
	input  logic    start,
	input  vecCmd_s cmd,
	input  logic    issueLast,
	input  logic    wbLast,
	input  logic    wbVld,
	output logic    issueClr,
	output logic    issueCnt,
	output logic    wbClr,
	output logic    issueVld, // Lines up with operand buffer data
	output vecCmd_s runCmd, // Latched command for both counters
	output logic    busy,
	output logic    done
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN
	} ctrlState_e;

	ctrlState_e state;
	logic       accept;

	// Empty runs never leave IDLE
	assign accept = (state == IDLE) && start && (cmd.len != 8'd0);

	assign issueClr = accept;
	assign wbClr    = accept;
	assign issueCnt = (state == ISSUE); // One element per enabled cycle
	assign busy     = (state != IDLE);

	always_ff @(posedge aclk) begin
		if (rst) begin
			state    <= IDLE;
			runCmd   <= '0;
			issueVld <= 1'b0;
			done     <= 1'b0;
		end else if (aclken) begin
			issueVld <= issueCnt; // Buffer read takes one cycle
			done     <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						runCmd <= cmd;
						state  <= ISSUE;
					end
				end
				ISSUE: begin
					if (issueLast)
						state <= DRAIN; // Last index going out now
				end
				DRAIN: begin
					// Final product being written this cycle
					if (wbVld && wbLast) begin
						done  <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Host must wait for done before the next start
	noStartBusy: assert property (@(posedge aclk) disable iff (rst)
		(aclken && busy) |-> !start)
		else $error("vecMulCtrl start while busy");

endmodule

/* hw/vecMulPkg.sv */
package vecMulPkg;

	import fpFormatPkg::*;

	// One operand buffer entry
	typedef struct packed {
		fp16Word_u a;
		fp16Word_u b;
	} opPair_s;

	// Run command from the host
	// len of zero is ignored by the controller
	typedef struct packed {
		logic [7:0] len; // Element count, at most DEPTH
	} vecCmd_s;

endpackage

/* hw/vecMulTop.sv */
`timescale 1ns/1ps

module vecMulTop import fpFormatPkg::*, vecMulPkg::*; #(
	parameter int DEPTH = 64
) (
	input  logic                     aclk,
	input  logic                     rst,
	input  logic                     aclken,
	input  logic                     ldEn,
	input  logic [$clog2(DEPTH)-1:0] ldAddr,
	input  opPair_s                  ldPair,
	input  logic                     start,
	input  vecCmd_s                  cmd,
	output logic                     busy,
	output logic                     done,
	input  logic [$clog2(DEPTH)-1:0] rdAddr,
	output mulResult_s               rdData // One cycle after rdAddr
);

	localparam int AW = $clog2(DEPTH);

	logic          issueClr;
	logic          issueCnt;
	logic          issueLast;
	logic          issueVld;
	logic [AW-1:0] issueIdx; // Operand read address
	logic          wbClr;
	logic          wbLast;
	logic [AW-1:0] wbIdx; // Result write address
	vecCmd_s       runCmd;
	opPair_s       opData;
	logic          mulVld;
	mulResult_s    mulRes;

	vecMulCtrl uCtrl (
		.aclk      (aclk),
		.rst       (rst),
		.aclken    (aclken),
		.start     (start),
		.cmd       (cmd),
		.issueLast (issueLast),
		.wbLast    (wbLast),
		.wbVld     (mulVld),
		.issueClr  (issueClr),
		.issueCnt  (issueCnt),
		.wbClr     (wbClr),
		.issueVld  (issueVld),
		.runCmd    (runCmd),
		.busy      (busy),
		.done      (done)
	);

	// Issue side
	elemCounter #(.DEPTH(DEPTH)) uIssueCnt (
		.aclk   (aclk),
		.rst    (rst),
		.aclken (aclken),
		.clear  (issueClr),
		.count  (issueCnt),
		.limit  (runCmd),
		.idx    (issueIdx),
		.last   (issueLast)
	);

	// Writeback side, steps on every product
	elemCounter #(.DEPTH(DEPTH)) uWbCnt (
		.aclk   (aclk),
		.rst    (rst),
		.aclken (aclken),
		.clear  (wbClr),
		.count  (mulVld),
		.limit  (runCmd),
		.idx    (wbIdx),
		.last   (wbLast)
	);

	// Host loads any cycle, read freezes with the pipe
	wordRam #(.DEPTH(DEPTH), .WIDTH($bits(opPair_s))) uOpRam (
		.aclk   (aclk),
		.wrEn   (ldEn),
		.wrAddr (ldAddr),
		.wrData (ldPair),
		.rdEn   (aclken),
		.rdAddr (issueIdx),
		.rdData (opData)
	);

	fp16Mul uMul (
		.aclk   (aclk),
		.rst    (rst),
		.aclken (aclken),
		.inVld  (issueVld),
		.inPair (opData),
		.outVld (mulVld),
		.outRes (mulRes)
	);

	// Host read port ignores aclken
	wordRam #(.DEPTH(DEPTH), .WIDTH($bits(mulResult_s))) uResRam (
		.aclk   (aclk),
		.wrEn   (mulVld & aclken), // Once per product even across stalls
		.wrAddr (wbIdx),
		.wrData (mulRes),
		.rdEn   (1'b1),
		.rdAddr (rdAddr),
		.rdData (rdData)
	);

endmodule

/* hw/wordRam.sv */
`timescale 1ns/1ps

module wordRam #(
	parameter int DEPTH = 64,
	parameter int WIDTH = 32 // 32 for operand pairs, 21 for results
) (
	input  logic                     aclk,
	input  logic                     wrEn,
	input  logic [$clog2(DEPTH)-1:0] wrAddr,
	input  logic [WIDTH-1:0]         wrData,
	input  logic                     rdEn, // Holds rdData when low
	input  logic [$clog2(DEPTH)-1:0] rdAddr,
	output logic [WIDTH-1:0]         rdData
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge aclk) begin
		if (wrEn)
			mem[wrAddr] <= wrData;
		if (rdEn)
			rdData <= mem[rdAddr]; // Old data on same address collision
	end

	// Host load address or writeback index out of range
	wrInRange: assert property (@(posedge aclk)
		wrEn |-> int'(wrAddr) < DEPTH)
		else $error("wordRam write to %0d beyond DEPTH", wrAddr);

endmodule

/* vecMulTop.f */
hw/fpFormatPkg.sv
hw/vecMulPkg.sv
hw/fp16MulPrep.sv
hw/fp16MulNormRound.sv
hw/fp16Mul.sv
hw/elemCounter.sv
hw/wordRam.sv
hw/vecMulCtrl.sv
hw/vecMulTop.sv
verif/vecMulTb.sv

/* verif/vecMulTb.sv */
`timescale 1ns/1ps

module vecMulTb
	import fpFormatPkg::*, vecMulPkg::*;
();

	localparam int DEPTH   = 64;
	localparam int AW      = $clog2(DEPTH);
	localparam int NVEC    = 32; // Random pairs per run
	localparam int NDIR    = 13; // Directed rounding and exception pairs
	localparam int TIMEOUT = 2000; // Clock cycles per wait

	logic          aclk = 1'b0;
	logic          rst;
	logic          aclken;
	logic          ldEn;
	logic [AW-1:0] ldAddr;
	opPair_s       ldPair;
	logic          start;
	vecCmd_s       cmd;
	logic          busy;
	logic          done;
	logic [AW-1:0] rdAddr;
	mulResult_s    rdData;

	int         seed = 32'h78aa_b4f6;
	int         dataErrs = 0;
	int         protoErrs = 0;
	int         timeoutErrs = 0;
	int         stallLeft; // Remaining cycles of the current stall
	mulResult_s expTab [DEPTH]; // Model result per buffer slot
	logic       rdChk; // Readback address valid this cycle
	mulResult_s expRes;
	logic       chkQ; // Aligned with rdData
	mulResult_s expQ;

	always #50 aclk = ~aclk;

	vecMulTop #(.DEPTH(DEPTH)) i_dut (
		.aclk   (aclk),
		.rst    (rst),
		.aclken (aclken),
		.ldEn   (ldEn),
		.ldAddr (ldAddr),
		.ldPair (ldPair),
		.start  (start),
		.cmd    (cmd),
		.busy   (busy),
		.done   (done),
		.rdAddr (rdAddr),
		.rdData (rdData)
	);

	// Read data shows up one cycle after the address
	always @(posedge aclk) begin
		chkQ <= rdChk;
		expQ <= expRes;
	end

	// Reference fp16 product, nearest even, flags from the inputs only
	function automatic mulResult_s refMul(fp16Word_u a, fp16Word_u b);
		mulResult_s  r;
		logic [21:0] p;
		logic [21:0] q;
		logic [10:0] frac; // Bit 10 catches the rounding carry
		logic        g;
		logic        st;
		int          e;
		p    = {1'b1, a.f.mant} * {1'b1, b.f.mant};
		q    = p[21] ? (p >> 1) : p; // Leading one at bit 20
		g    = q[9];
		st   = (|q[8:0]) | (p[21] & p[0]); // Bit shifted out still counts
		frac = {1'b0, q[19:10]};
		e    = int'(a.f.exp) + int'(b.f.exp) - 15 + int'(p[21]);
		if (g && (st || frac[0]))
			frac = frac + 11'd1;
		if (frac[10]) begin
			frac = '0; // 1.11..1 rounded up to 2.0
			e    = e + 1;
		end
		r.prod.f.sign = a.f.sign ^ b.f.sign;
		r.prod.f.exp  = e[4:0];
		r.prod.f.mant = frac[9:0];
		r.exc.aNaN    = (a.f.exp == 5'h1f) && (a.f.mant != 10'd0);
		r.exc.bNaN    = (b.f.exp == 5'h1f) && (b.f.mant != 10'd0);
		r.exc.aInf    = (a.f.exp == 5'h1f) && (a.f.mant == 10'd0);
		r.exc.bInf    = (b.f.exp == 5'h1f) && (b.f.mant == 10'd0);
		r.exc.anyExc  = r.exc.aNaN | r.exc.bNaN | r.exc.aInf | r.exc.bInf;
		return r;
	endfunction

	function automatic fp16Word_u mkWord(logic s, logic [4:0] e, logic [9:0] m);
		fp16Word_u w;
		w.f.sign = s;
		w.f.exp  = e;
		w.f.mant = m;
		return w;
	endfunction

	// Exponent 8 to 22 keeps every product normal
	function automatic fp16Word_u randNormal();
		fp16Word_u w;
		w.f.sign = $random(seed) & 1;
		w.f.exp  = 5'(8 + $unsigned($random(seed)) % 15);
		w.f.mant = 10'($random(seed));
		return w;
	endfunction

	task automatic nextCycle();
		@(posedge aclk);
		#1; // Inputs change just after the edge
	endtask

	task automatic loadPair(int idx, fp16Word_u a, fp16Word_u b);
		ldEn         = 1'b1;
		ldAddr       = AW'(idx);
		ldPair.a     = a;
		ldPair.b     = b;
		expTab[idx]  = refMul(a, b);
		nextCycle();
		ldEn         = 1'b0;
	endtask

	task automatic loadDirected();
		loadPair(0, mkWord(0, 15, 10'h003), mkWord(0, 15, 10'h200)); // Tie, even kept bit
		loadPair(1, mkWord(1, 15, 10'h001), mkWord(0, 15, 10'h200)); // Tie, odd kept bit
		loadPair(2, mkWord(0, 14, 10'h1a8), mkWord(0, 16, 10'h1a8)); // Carry into exponent
		loadPair(3, mkWord(0, 15, 10'h000), randNormal()); // Exact
		loadPair(4, mkWord(0, 31, 10'h155), randNormal()); // NaN on a
		loadPair(5, randNormal(), mkWord(1, 31, 10'h001)); // NaN on b
		loadPair(6, mkWord(1, 31, 10'h000), randNormal()); // Inf on a
		loadPair(7, randNormal(), mkWord(0, 31, 10'h000)); // Inf on b
		loadPair(8, mkWord(0, 31, 10'h200), mkWord(1, 31, 10'h000));
		loadPair(9, mkWord(0, 31, 10'h000), mkWord(0, 31, 10'h000));
		loadPair(10, mkWord(1, 31, 10'h3ff), mkWord(0, 31, 10'h0f0));
		loadPair(11, mkWord(0, 15, 10'h200), mkWord(1, 15, 10'h156)); // High tie, even
		loadPair(12, mkWord(0, 15, 10'h200), mkWord(0, 15, 10'h15a)); // High tie, odd
	endtask

	task automatic startRun(int len);
		aclken  = 1'b1; // Start only counts on an enabled cycle
		start   = 1'b1;
		cmd.len = 8'(len);
		nextCycle();
		start   = 1'b0;
	endtask

	// Optionally stalls the engine in random stretches while waiting
	task automatic waitDone(input bit stall, output bit ok);
		int n;
		ok        = 1'b0;
		n         = 0;
		stallLeft = 0;
		while (!ok && n < TIMEOUT) begin
			if (!stall) begin
				aclken = 1'b1;
			end else if (stallLeft > 0) begin
				aclken    = 1'b0;
				stallLeft = stallLeft - 1;
			end else if (($random(seed) & 3) == 0) begin
				aclken    = 1'b0; // New stretch, 1 to 6 cycles
				stallLeft = $unsigned($random(seed)) % 6;
			end else begin
				aclken = 1'b1;
			end
			nextCycle();
			ok = done;
			n  = n + 1;
		end
		aclken = 1'b1;
		if (!ok) begin
			timeoutErrs = timeoutErrs + 1;
			$display("Timeout: no done pulse within %0d cycles at %0t", TIMEOUT, $time);
		end
	endtask

	task automatic readBack(int n);
		int i;
		for (i = 0; i < n; i++) begin
			rdAddr = AW'(i);
			expRes = expTab[i];
			rdChk  = 1'b1;
			nextCycle();
		end
		rdChk = 1'b0;
		nextCycle();
		nextCycle(); // Last compare lands here
	endtask

	task automatic runVector(int len, bit stall);
		bit ok;
		startRun(len);
		waitDone(stall, ok);
		if (ok)
			readBack(len);
	endtask

	task automatic finishRun();
		$display("Errors: data %0d, protocol %0d, timeout %0d",
			dataErrs, protoErrs, timeoutErrs);
		if (dataErrs + protoErrs + timeoutErrs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	initial begin
		int i;
		bit ok;
		rst       = 1'b1;
		aclken    = 1'b1;
		ldEn      = 1'b0;
		ldAddr    = '0;
		ldPair    = '0;
		start     = 1'b0;
		cmd       = '0;
		rdAddr    = '0;
		rdChk     = 1'b0;
		expRes    = '0;
		stallLeft = 0;
		repeat (10) @(posedge aclk);
		#1;
		rst = 1'b0;
		nextCycle();

		for (i = 0; i < NVEC; i++)
			loadPair(i, randNormal(), randNormal());
		runVector(NVEC, 1'b0);

		if (timeoutErrs == 0) begin
			loadDirected();
			runVector(NDIR, 1'b0);
		end

		// Same kind of run with the engine frozen now and then
		if (timeoutErrs == 0) begin
			for (i = 0; i < NVEC; i++)
				loadPair(i, randNormal(), randNormal());
			runVector(NVEC, 1'b1);
		end

		// Length 1 then a full buffer with no gap
		if (timeoutErrs == 0) begin
			for (i = 0; i < DEPTH; i++)
				loadPair(i, randNormal(), randNormal());
			startRun(1);
			waitDone(1'b0, ok);
			if (ok) begin
				startRun(DEPTH);
				waitDone(1'b0, ok);
			end
			if (ok)
				readBack(DEPTH);
		end

		finishRun();
	end

	// Checks sample on the falling edge, between the drive points
	prodCheck: assert property (@(negedge aclk) disable iff (rst)
		chkQ |-> rdData.prod.raw == expQ.prod.raw)
		else begin
			dataErrs = dataErrs + 1;
			$display("MISMATCH rdData.prod got %h expected %h at %0t",
				rdData.prod.raw, expQ.prod.raw, $time);
		end

	excCheck: assert property (@(negedge aclk) disable iff (rst)
		chkQ |-> rdData.exc == expQ.exc)
		else begin
			dataErrs = dataErrs + 1;
			$display("MISMATCH rdData.exc got %h expected %h at %0t",
				rdData.exc, expQ.exc, $time);
		end

	resetQuiet: assert property (@(negedge aclk)
		$fell(rst) |-> !busy && !done && !i_dut.mulVld && !i_dut.issueVld)
		else begin
			protoErrs = protoErrs + 1;
			$display("Busy, done or a valid strobe is high right after reset");
		end

	startTaken: assert property (@(negedge aclk) disable iff (rst)
		(start && aclken && !busy && cmd.len != 8'd0) |=> busy)
		else begin
			protoErrs = protoErrs + 1;
			$display("Start was not taken, busy stayed low at %0t", $time);
		end

	busyUntilDone: assert property (@(negedge aclk) disable iff (rst)
		$fell(busy) |-> done)
		else begin
			protoErrs = protoErrs + 1;
			$display("Busy dropped without a done pulse at %0t", $time);
		end

	doneIdle: assert property (@(negedge aclk) disable iff (rst)
		done |-> !busy)
		else begin
			protoErrs = protoErrs + 1;
			$display("Busy still high during done at %0t", $time);
		end

	donePulse: assert property (@(negedge aclk) disable iff (rst)
		(done && aclken) |=> !done)
		else begin
			protoErrs = protoErrs + 1;
			$display("Done lasted more than one enabled cycle at %0t", $time);
		end

endmodule
